/* rs_types_pkg.sv */
`default_nettype none

package rs_types_pkg;

    // physical register tag, 128 physical registers
    typedef logic [6:0] phys_tag_t;

    // sequence id so each micro-op can be traced end to end
    typedef logic [7:0] uop_id_t;

    // operation code, passed through untouched
    typedef logic [5:0] opcode_t;

    // default station depth
    // top level overrides through NUM_ENTRIES
    parameter int RS_ENTRIES_DEFAULT = 8;

endpackage

`default_nettype wire

/* rs_uop_pkg.sv */
`default_nettype none

package rs_uop_pkg;

    // renamed micro-op on a dispatch lane, 37 bits
    typedef struct packed {
        rs_types_pkg::uop_id_t   uop_id;
        rs_types_pkg::opcode_t   opcode;
        rs_types_pkg::phys_tag_t src1_tag;
        logic                    src1_rdy;
        rs_types_pkg::phys_tag_t src2_tag;
        logic                    src2_rdy;
        rs_types_pkg::phys_tag_t dst_tag;
    } dispatch_uop_t;

    // what leaves the station toward the functional unit, 21 bits
    // sources are dropped, only the destination tag travels on
    typedef struct packed {
        rs_types_pkg::uop_id_t   uop_id;
        rs_types_pkg::opcode_t   opcode;
        rs_types_pkg::phys_tag_t dst_tag;
    } issue_uop_t;

    // result tag broadcast, one per cycle
    typedef struct packed {
        logic                    valid;
        rs_types_pkg::phys_tag_t tag;
    } wakeup_t;

endpackage

`default_nettype wire

/* rs_free_slot.sv */
`timescale 1ns/100ps
`default_nettype none

module rs_free_slot #(
    parameter int NUM_ENTRIES = 8
) (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           list_init,
    input  wire logic                           alloc_0,
    input  wire logic                           alloc_1,
    output logic [$clog2(NUM_ENTRIES)-1:0]      slot_0,
    output logic [$clog2(NUM_ENTRIES)-1:0]      slot_1,
    input  wire logic                           release_valid,
    input  wire logic [$clog2(NUM_ENTRIES)-1:0] release_slot,
    output logic [$clog2(NUM_ENTRIES):0]        free_count
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);
    localparam int CNT_W = IDX_W + 1;

    // circular list of free slot numbers
    logic [IDX_W-1:0] slot_list [NUM_ENTRIES];
    // head: oldest free slot, tail: last slot put back
    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] tail;
    logic [IDX_W-1:0] head_next1;
    logic [IDX_W-1:0] tail_next1;
    logic [CNT_W-1:0] count_next;

    // pointers wrap naturally, depth is a power of two
    assign head_next1 = head + 1'b1;
    assign tail_next1 = tail + 1'b1;

    // lane 0 always looks at the head
    // lane 1 takes the head alone, or the one after when both allocate
    assign slot_0 = slot_list[head];
    assign slot_1 = alloc_0 ? slot_list[head_next1] : slot_list[head];

    // net change this cycle: one release in, up to two allocations out
    always_comb begin
        count_next = free_count;
        if (release_valid) begin
            count_next = count_next + 1'b1;
        end
        count_next = count_next - CNT_W'(alloc_0) - CNT_W'(alloc_1);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // identity order, every slot free
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                slot_list[i] <= IDX_W'(i);
            end
            head       <= '0;
            tail       <= IDX_W'(NUM_ENTRIES - 1);
            free_count <= CNT_W'(NUM_ENTRIES);
        end else if (list_init) begin
            // recovery, same refill as reset
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                slot_list[i] <= IDX_W'(i);
            end
            head       <= '0;
            tail       <= IDX_W'(NUM_ENTRIES - 1);
            free_count <= CNT_W'(NUM_ENTRIES);
        end else begin
            // advance head by the number of slots handed out
            if (alloc_0 && alloc_1) begin
                head <= head + 2'd2;
            end else if (alloc_0 || alloc_1) begin
                head <= head_next1;
            end
            // issued slot goes in just past the tail
            if (release_valid) begin
                slot_list[tail_next1] <= release_slot;
                tail                  <= tail_next1;
            end
            free_count <= count_next;
        end
    end

endmodule

`default_nettype wire

/* rs_entry_array.sv */
`timescale 1ns/100ps
`default_nettype none

module rs_entry_array #(
    parameter int NUM_ENTRIES = rs_types_pkg::RS_ENTRIES_DEFAULT
) (
    input  wire logic                                     clk,
    input  wire logic                                     rst,
    input  wire logic                                     clear_all,
    input  wire logic                                     alloc_0,
    input  wire logic                                     alloc_1,
    input  wire logic [$clog2(NUM_ENTRIES)-1:0]           slot_0,
    input  wire logic [$clog2(NUM_ENTRIES)-1:0]           slot_1,
    input  wire rs_uop_pkg::dispatch_uop_t                disp_uop_0,
    input  wire rs_uop_pkg::dispatch_uop_t                disp_uop_1,
    input  wire rs_uop_pkg::wakeup_t                      wakeup,
    input  wire logic                                     issue_grant,
    input  wire logic [$clog2(NUM_ENTRIES)-1:0]           grant_slot,
    output logic [NUM_ENTRIES-1:0]                        entry_ready,
    output rs_uop_pkg::issue_uop_t [NUM_ENTRIES-1:0]      entry_payload
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    // source operand tag plus its ready flag
    typedef struct packed {
        rs_types_pkg::phys_tag_t tag;
        logic                    rdy;
    } src_t;

    logic                 valid_q [NUM_ENTRIES];
    // index 0 is src1 and index 1 is src2
    src_t [1:0]           src_q   [NUM_ENTRIES];
    src_t [1:0]           in_src_0;
    src_t [1:0]           in_src_1;
    logic [NUM_ENTRIES-1:0] wr_0;
    logic [NUM_ENTRIES-1:0] wr_1;
    logic [NUM_ENTRIES-1:0] clr;
    logic [NUM_ENTRIES-1:0] ready_q;

    // set ready when the broadcast tag matches
    function automatic src_t wake(src_t s, rs_uop_pkg::wakeup_t w);
        src_t r;
        r     = s;
        r.rdy = s.rdy | (w.valid && (w.tag == s.tag));
        return r;
    endfunction

    // keep only the fields the functional unit needs
    function automatic rs_uop_pkg::issue_uop_t to_issue(rs_uop_pkg::dispatch_uop_t d);
        rs_uop_pkg::issue_uop_t r;
        r.uop_id  = d.uop_id;
        r.opcode  = d.opcode;
        r.dst_tag = d.dst_tag;
        return r;
    endfunction

    // incoming sources already see this cycle's broadcast
    assign in_src_0[0] = wake('{tag: disp_uop_0.src1_tag, rdy: disp_uop_0.src1_rdy}, wakeup);
    assign in_src_0[1] = wake('{tag: disp_uop_0.src2_tag, rdy: disp_uop_0.src2_rdy}, wakeup);
    assign in_src_1[0] = wake('{tag: disp_uop_1.src1_tag, rdy: disp_uop_1.src1_rdy}, wakeup);
    assign in_src_1[1] = wake('{tag: disp_uop_1.src2_tag, rdy: disp_uop_1.src2_rdy}, wakeup);

    // per-entry decode of writes and the issue grant
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            wr_0[i] = alloc_0 && (slot_0 == IDX_W'(i));
            wr_1[i] = alloc_1 && (slot_1 == IDX_W'(i));
            clr[i]  = issue_grant && (grant_slot == IDX_W'(i));
        end
    end

    // valid and ready bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (clear_all) begin
                    valid_q[i] <= 1'b0;
                end else if (wr_0[i] || wr_1[i]) begin
                    valid_q[i] <= 1'b1;
                end else if (clr[i]) begin
                    valid_q[i] <= 1'b0;
                end
            end
        end
    end

    // source tags and payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (wr_0[i]) begin
                src_q[i]         <= in_src_0;
                entry_payload[i] <= to_issue(disp_uop_0);
            end else if (wr_1[i]) begin
                src_q[i]         <= in_src_1;
                entry_payload[i] <= to_issue(disp_uop_1);
            end else begin
                // waiting sources watch the broadcast
                src_q[i][0] <= wake(src_q[i][0], wakeup);
                src_q[i][1] <= wake(src_q[i][1], wakeup);
            end
        end
    end

    // ready reaches the select block one edge after the sources settle
    // a granted entry drops out at once
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_q <= '0;
        end else begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                ready_q[i] <= valid_q[i] && src_q[i][0].rdy && src_q[i][1].rdy
                              && !clr[i] && !clear_all;
            end
        end
    end

    // masked during recovery so flushed ops never get picked
    assign entry_ready = ready_q & ~{NUM_ENTRIES{clear_all}};

endmodule

`default_nettype wire

/* rs_issue_select.sv */
`timescale 1ns/100ps
`default_nettype none

module rs_issue_select #(
    parameter int NUM_ENTRIES = rs_types_pkg::RS_ENTRIES_DEFAULT
) (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic [NUM_ENTRIES-1:0]              entry_ready,
    input  wire rs_uop_pkg::issue_uop_t [NUM_ENTRIES-1:0] entry_payload,
    output logic                                     issue_grant,
    output logic [$clog2(NUM_ENTRIES)-1:0]           grant_slot,
    output logic                                     issue_valid,
    output rs_uop_pkg::issue_uop_t                   issue_uop
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    // any ready entry wins a grant this cycle
    assign issue_grant = |entry_ready;

    // priority search, lowest index wins
    // scan from the top so the last hit is the lowest
    always_comb begin
        grant_slot = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (entry_ready[i]) begin
                grant_slot = IDX_W'(i);
            end
        end
    end

    // issue strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= issue_grant;
        end
    end

    // issued micro-op, held until the next grant
    always_ff @(posedge clk) begin
        if (issue_grant) begin
            issue_uop <= entry_payload[grant_slot];
        end
    end

endmodule

`default_nettype wire

/* rs_dispatch_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module rs_dispatch_ctrl #(
    parameter int NUM_ENTRIES = rs_types_pkg::RS_ENTRIES_DEFAULT
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         flush,
    input  wire logic                         disp_valid_0,
    input  wire logic                         disp_valid_1,
    input  wire logic [$clog2(NUM_ENTRIES):0] free_count,
    output logic                              dispatch_ready,
    output logic                              alloc_0,
    output logic                              alloc_1,
    output logic                              list_init,
    output logic                              clear_all
);

    localparam int CNT_W = $clog2(NUM_ENTRIES) + 1;

    typedef enum logic [1:0] {
        st_init,
        st_run,
        st_flush
    } state_t;

    state_t state;
    state_t state_next;

    // next state
    always_comb begin
        state_next = state;
        case (state)
            st_init: begin
                // reset already filled the list, just wait a cycle
                state_next = st_run;
            end
            st_run: begin
                state_next = st_run;
            end
            st_flush: begin
                // one recovery cycle
                state_next = st_run;
            end
            default: begin
                state_next = st_init;
            end
        endcase
        // flush wins from any state
        if (flush) begin
            state_next = st_flush;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_init;
        end else begin
            state <= state_next;
        end
    end

    // room for two is required, a lane pair may both fire
    // free_count is registered so this cycle's release is not counted
    assign dispatch_ready = (state == st_run) && (free_count >= CNT_W'(2));

    // lane valids only count while ready
    assign alloc_0 = disp_valid_0 && dispatch_ready;
    assign alloc_1 = disp_valid_1 && dispatch_ready;

    // recovery strobes for the list and the array
    assign list_init = (state == st_flush);
    assign clear_all = (state == st_flush);

endmodule

`default_nettype wire

/* rs_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rs_top #(
    parameter int NUM_ENTRIES = rs_types_pkg::RS_ENTRIES_DEFAULT
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      disp_valid_0,
    input  wire logic                      disp_valid_1,
    input  wire rs_uop_pkg::dispatch_uop_t disp_uop_0,
    input  wire rs_uop_pkg::dispatch_uop_t disp_uop_1,
    output logic                           dispatch_ready,
    input  wire rs_uop_pkg::wakeup_t       wakeup,
    input  wire logic                      flush,
    output logic                           issue_valid,
    output rs_uop_pkg::issue_uop_t         issue_uop,
    output logic [$clog2(NUM_ENTRIES):0]   free_count
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    // control to datapath
    logic alloc_0;
    logic alloc_1;
    logic list_init;
    logic clear_all;
    // free list to array
    logic [IDX_W-1:0] slot_0;
    logic [IDX_W-1:0] slot_1;
    // array to select and back
    logic [NUM_ENTRIES-1:0]                   entry_ready;
    rs_uop_pkg::issue_uop_t [NUM_ENTRIES-1:0] entry_payload;
    logic                                     issue_grant;
    logic [IDX_W-1:0]                         grant_slot;

    rs_dispatch_ctrl #(.NUM_ENTRIES(NUM_ENTRIES)) u_ctrl (
        .clk(clk), .rst(rst), .flush(flush),
        .disp_valid_0(disp_valid_0), .disp_valid_1(disp_valid_1),
        .free_count(free_count), .dispatch_ready(dispatch_ready),
        .alloc_0(alloc_0), .alloc_1(alloc_1),
        .list_init(list_init), .clear_all(clear_all)
    );

    // granted slot goes straight back to the list
    rs_free_slot #(.NUM_ENTRIES(NUM_ENTRIES)) u_free_slot (
        .clk(clk), .rst(rst), .list_init(list_init),
        .alloc_0(alloc_0), .alloc_1(alloc_1),
        .slot_0(slot_0), .slot_1(slot_1),
        .release_valid(issue_grant), .release_slot(grant_slot),
        .free_count(free_count)
    );

    rs_entry_array #(.NUM_ENTRIES(NUM_ENTRIES)) u_entries (
        .clk(clk), .rst(rst), .clear_all(clear_all),
        .alloc_0(alloc_0), .alloc_1(alloc_1),
        .slot_0(slot_0), .slot_1(slot_1),
        .disp_uop_0(disp_uop_0), .disp_uop_1(disp_uop_1),
        .wakeup(wakeup), .issue_grant(issue_grant), .grant_slot(grant_slot),
        .entry_ready(entry_ready), .entry_payload(entry_payload)
    );

    rs_issue_select #(.NUM_ENTRIES(NUM_ENTRIES)) u_select (
        .clk(clk), .rst(rst),
        .entry_ready(entry_ready), .entry_payload(entry_payload),
        .issue_grant(issue_grant), .grant_slot(grant_slot),
        .issue_valid(issue_valid), .issue_uop(issue_uop)
    );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    // free-running clock
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // reset held for a few edges, released just after one
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

`default_nettype wire

/* tb_rs.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rs;

    localparam int NUM_ENTRIES = 8;
    localparam int CNT_W       = $clog2(NUM_ENTRIES) + 1;
    localparam int DRIVE_DLY   = 2;
    // tags that start out not ready in the random mix
    localparam int TAG_POOL    = 32;

    logic                      clk;
    logic                      rst;
    logic                      disp_valid_0;
    logic                      disp_valid_1;
    rs_uop_pkg::dispatch_uop_t disp_uop_0;
    rs_uop_pkg::dispatch_uop_t disp_uop_1;
    logic                      dispatch_ready;
    rs_uop_pkg::wakeup_t       wakeup;
    logic                      flush;
    logic                      issue_valid;
    rs_uop_pkg::issue_uop_t    issue_uop;
    logic [CNT_W-1:0]          free_count;

    // scoreboard of ready micro-ops keyed by id
    rs_uop_pkg::issue_uop_t    exp_uops [rs_types_pkg::uop_id_t];
    // edge at which each one became ready
    int                        ready_edge [rs_types_pkg::uop_id_t];
    // accepted but still waiting on a source
    rs_uop_pkg::dispatch_uop_t waiting [$];

    int                    edge_cnt;
    int                    errors;
    int                    checks;
    int                    test_errors;
    int                    test_num;
    int                    accepted;
    int                    issued;
    int                    last_acc;
    rs_types_pkg::uop_id_t next_id;

    tb_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(4)) u_clk_gen (
        .clk(clk),
        .rst(rst)
    );

    rs_top #(.NUM_ENTRIES(NUM_ENTRIES)) uut (
        .clk(clk), .rst(rst),
        .disp_valid_0(disp_valid_0), .disp_valid_1(disp_valid_1),
        .disp_uop_0(disp_uop_0), .disp_uop_1(disp_uop_1),
        .dispatch_ready(dispatch_ready), .wakeup(wakeup), .flush(flush),
        .issue_valid(issue_valid), .issue_uop(issue_uop), .free_count(free_count)
    );

    // counts rising edges from zero
    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic check_uop(input string name, input rs_uop_pkg::issue_uop_t exp,
                             input rs_uop_pkg::issue_uop_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] exp,
                               input logic [CNT_W-1:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    // totals kept by the testbench itself
    task automatic check_total(input string name, input int exp, input int got);
        checks++;
        if (got != exp) begin
            errors++;
            $display("error at %0t ns: %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    function automatic rs_uop_pkg::dispatch_uop_t make_uop(
        input rs_types_pkg::uop_id_t id, input rs_types_pkg::opcode_t op,
        input rs_types_pkg::phys_tag_t t1, input logic r1,
        input rs_types_pkg::phys_tag_t t2, input logic r2,
        input rs_types_pkg::phys_tag_t dst);
        rs_uop_pkg::dispatch_uop_t d;
        d.uop_id   = id;
        d.opcode   = op;
        d.src1_tag = t1;
        d.src1_rdy = r1;
        d.src2_tag = t2;
        d.src2_rdy = r2;
        d.dst_tag  = dst;
        return d;
    endfunction

    // half the sources wait on a pool tag
    function automatic rs_uop_pkg::dispatch_uop_t random_uop(input rs_types_pkg::uop_id_t id);
        logic r1;
        logic r2;
        r1 = $urandom % 2;
        r2 = $urandom % 2;
        return make_uop(id, rs_types_pkg::opcode_t'($urandom),
            rs_types_pkg::phys_tag_t'(r1 ? $urandom % TAG_POOL : TAG_POOL + $urandom % 8), r1,
            rs_types_pkg::phys_tag_t'(r2 ? $urandom % TAG_POOL : TAG_POOL + $urandom % 8), r2,
            rs_types_pkg::phys_tag_t'($urandom));
    endfunction

    // a matching broadcast marks a source ready
    function automatic rs_uop_pkg::dispatch_uop_t apply_wakeup(
        input rs_uop_pkg::dispatch_uop_t d, input rs_uop_pkg::wakeup_t w);
        rs_uop_pkg::dispatch_uop_t r;
        r = d;
        if (w.valid && (w.tag == d.src1_tag))
            r.src1_rdy = 1'b1;
        if (w.valid && (w.tag == d.src2_tag))
            r.src2_rdy = 1'b1;
        return r;
    endfunction

    // ready ops go to the scoreboard, others keep waiting
    task automatic enter(input rs_uop_pkg::dispatch_uop_t d);
        rs_uop_pkg::issue_uop_t e;
        if (d.src1_rdy && d.src2_rdy) begin
            e.uop_id  = d.uop_id;
            e.opcode  = d.opcode;
            e.dst_tag = d.dst_tag;
            exp_uops[d.uop_id]   = e;
            ready_edge[d.uop_id] = edge_cnt;
        end else begin
            waiting.push_back(d);
        end
    endtask

    task automatic check_issue();
        rs_types_pkg::uop_id_t id;
        id = issue_uop.uop_id;
        checks++;
        if (!exp_uops.exists(id)) begin
            errors++;
            $display("at %0t ns micro-op %0d issued while not ready or not held", $time, id);
        end else begin
            check_uop("issue_uop", exp_uops[id], issue_uop);
            // minimum latency is two edges after becoming ready
            if (edge_cnt < ready_edge[id] + 2) begin
                errors++;
                $display("at %0t ns micro-op %0d issued too early", $time, id);
            end
            exp_uops.delete(id);
            ready_edge.delete(id);
            issued++;
        end
    endtask

    task automatic drive_idle();
        disp_valid_0 = 1'b0;
        disp_valid_1 = 1'b0;
        disp_uop_0   = '0;
        disp_uop_1   = '0;
        wakeup       = '0;
        flush        = 1'b0;
    endtask

    // one clock, returns at the next drive point with inputs idle
    task automatic tick();
        logic                      acc;
        logic                      v0;
        logic                      v1;
        logic                      fl;
        rs_uop_pkg::dispatch_uop_t u0;
        rs_uop_pkg::dispatch_uop_t u1;
        rs_uop_pkg::wakeup_t       w;
        rs_uop_pkg::dispatch_uop_t still [$];
        // mid cycle with inputs settled
        @(negedge clk);
        acc = dispatch_ready;
        v0  = disp_valid_0 && acc;
        v1  = disp_valid_1 && acc;
        u0  = disp_uop_0;
        u1  = disp_uop_1;
        w   = wakeup;
        fl  = flush;
        @(posedge clk);
        #1;
        // this issue comes from a grant before the edge
        if (issue_valid)
            check_issue();
        foreach (waiting[i]) begin
            still.push_back(waiting[i]);
        end
        waiting.delete();
        foreach (still[i]) begin
            enter(apply_wakeup(still[i], w));
        end
        // new entries also see the same-cycle broadcast
        if (v0)
            enter(apply_wakeup(u0, w));
        if (v1)
            enter(apply_wakeup(u1, w));
        last_acc = int'(v0) + int'(v1);
        accepted += last_acc;
        next_id = rs_types_pkg::uop_id_t'(next_id + last_acc);
        // recovery drops everything held
        if (fl) begin
            waiting.delete();
            exp_uops.delete();
            ready_edge.delete();
        end
        #(DRIVE_DLY - 1);
        drive_idle();
    endtask

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        while (!dispatch_ready && n < limit) begin
            tick();
            n++;
        end
        if (!dispatch_ready) begin
            errors++;
            $display("timeout at %0t ns: dispatch_ready stayed low for %0d cycles", $time, limit);
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while ((exp_uops.num() != 0 || waiting.size() != 0) && n < limit) begin
            tick();
            n++;
        end
        if (exp_uops.num() != 0 || waiting.size() != 0) begin
            errors++;
            $display("timeout at %0t ns: %0d micro-ops still held after %0d cycles",
                     $time, exp_uops.num() + waiting.size(), limit);
        end
    endtask

    task automatic report_test(input string name);
        test_num++;
        if (errors == test_errors)
            $display("test %0d %s: ok", test_num, name);
        else
            $display("test %0d %s: %0d errors", test_num, name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic test_reset();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (rst !== 1'b0 && n < 20);
        if (rst !== 1'b0) begin
            errors++;
            $display("timeout at %0t ns: reset never released", $time);
        end
        // init state, one cycle before dispatch opens
        check_level("issue_valid", 1'b0, issue_valid);
        check_level("dispatch_ready", 1'b0, dispatch_ready);
        check_count("free_count", CNT_W'(NUM_ENTRIES), free_count);
        @(posedge clk);
        #DRIVE_DLY;
        wait_ready(10);
        report_test("reset");
    endtask

    task automatic test_dual();
        int iss0;
        iss0 = issued;
        disp_valid_0 = 1'b1;
        disp_uop_0   = make_uop(next_id, 6'h11, 7'd1, 1'b1, 7'd2, 1'b1, 7'd40);
        disp_valid_1 = 1'b1;
        disp_uop_1   = make_uop(rs_types_pkg::uop_id_t'(next_id + 1), 6'h22,
                                7'd3, 1'b1, 7'd4, 1'b1, 7'd41);
        tick();
        check_total("accepted lanes", 2, last_acc);
        wait_drain(20);
        check_total("issued micro-ops", 2, issued - iss0);
        check_count("free_count", CNT_W'(NUM_ENTRIES), free_count);
        report_test("dual dispatch");
    endtask

    task automatic test_wakeup();
        int iss0;
        iss0 = issued;
        // lane 0 waits on tag 50, lane 1 is woken in the dispatch cycle
        disp_valid_0 = 1'b1;
        disp_uop_0   = make_uop(next_id, 6'h05, 7'd50, 1'b0, 7'd9, 1'b1, 7'd42);
        disp_valid_1 = 1'b1;
        disp_uop_1   = make_uop(rs_types_pkg::uop_id_t'(next_id + 1), 6'h06,
                                7'd10, 1'b1, 7'd51, 1'b0, 7'd43);
        wakeup       = '{valid: 1'b1, tag: 7'd51};
        tick();
        // the waiting one must hold here
        repeat (6) tick();
        check_total("issued before wakeup", 1, issued - iss0);
        wakeup = '{valid: 1'b1, tag: 7'd50};
        tick();
        wait_drain(20);
        check_total("issued micro-ops", 2, issued - iss0);
        report_test("wakeup");
    endtask

    task automatic test_fill();
        int total;
        int n;
        total = 0;
        n = 0;
        while (dispatch_ready && n < 10) begin
            disp_valid_0 = 1'b1;
            disp_uop_0   = make_uop(next_id, 6'h0a, rs_types_pkg::phys_tag_t'(60 + 2 * n),
                                    1'b0, 7'd8, 1'b1, 7'd44);
            disp_valid_1 = 1'b1;
            disp_uop_1   = make_uop(rs_types_pkg::uop_id_t'(next_id + 1), 6'h0b,
                                    rs_types_pkg::phys_tag_t'(61 + 2 * n), 1'b0,
                                    7'd8, 1'b1, 7'd45);
            tick();
            total += last_acc;
            n++;
        end
        check_total("accepted before full", NUM_ENTRIES, total);
        check_level("dispatch_ready", 1'b0, dispatch_ready);
        check_count("free_count", '0, free_count);
        // lanes while full are ignored
        disp_valid_0 = 1'b1;
        disp_uop_0   = make_uop(next_id, 6'h0c, 7'd1, 1'b1, 7'd2, 1'b1, 7'd46);
        tick();
        check_count("free_count", '0, free_count);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            wakeup = '{valid: 1'b1, tag: rs_types_pkg::phys_tag_t'(60 + i)};
            tick();
        end
        wait_drain(30);
        wait_ready(5);
        check_count("free_count", CNT_W'(NUM_ENTRIES), free_count);
        report_test("fill and drain");
    endtask

    task automatic test_flush();
        for (int i = 0; i < 2; i++) begin
            disp_valid_0 = 1'b1;
            disp_uop_0   = make_uop(next_id, 6'h15, rs_types_pkg::phys_tag_t'(80 + 2 * i),
                                    1'b0, 7'd7, 1'b1, 7'd47);
            disp_valid_1 = 1'b1;
            disp_uop_1   = make_uop(rs_types_pkg::uop_id_t'(next_id + 1), 6'h16,
                                    7'd7, 1'b1, rs_types_pkg::phys_tag_t'(81 + 2 * i),
                                    1'b0, 7'd48);
            tick();
        end
        tick();
        flush = 1'b1;
        tick();
        // recovery cycle keeps dispatch closed
        check_level("dispatch_ready", 1'b0, dispatch_ready);
        wait_ready(10);
        check_count("free_count", CNT_W'(NUM_ENTRIES), free_count);
        // stale tags come back, nothing may issue
        for (int i = 0; i < 4; i++) begin
            wakeup = '{valid: 1'b1, tag: rs_types_pkg::phys_tag_t'(80 + i)};
            tick();
        end
        repeat (4) tick();
        disp_valid_0 = 1'b1;
        disp_uop_0   = make_uop(next_id, 6'h17, 7'd1, 1'b1, 7'd2, 1'b1, 7'd49);
        disp_valid_1 = 1'b1;
        disp_uop_1   = make_uop(rs_types_pkg::uop_id_t'(next_id + 1), 6'h18,
                                7'd1, 1'b1, 7'd2, 1'b1, 7'd50);
        tick();
        check_total("accepted lanes", 2, last_acc);
        wait_drain(20);
        report_test("flush");
    endtask

    task automatic test_random();
        int   acc0;
        int   iss0;
        int   n;
        logic v0;
        acc0    = accepted;
        iss0    = issued;
        next_id = '0;
        for (int c = 0; c < 200; c++) begin
            v0           = ($urandom % 10) < 4;
            disp_valid_0 = v0;
            disp_uop_0   = random_uop(next_id);
            disp_valid_1 = ($urandom % 10) < 4;
            disp_uop_1   = random_uop(rs_types_pkg::uop_id_t'(next_id + v0));
            if ($urandom % 2 == 1)
                wakeup = '{valid: 1'b1,
                           tag: rs_types_pkg::phys_tag_t'(TAG_POOL + $urandom % 8)};
            tick();
        end
        // sweep the pool until nothing is held
        n = 0;
        while ((exp_uops.num() != 0 || waiting.size() != 0) && n < 100) begin
            wakeup = '{valid: 1'b1, tag: rs_types_pkg::phys_tag_t'(TAG_POOL + n % 8)};
            tick();
            n++;
        end
        if (exp_uops.num() != 0 || waiting.size() != 0) begin
            errors++;
            $display("timeout at %0t ns: random mix left micro-ops in the station", $time);
        end
        check_total("issued micro-ops", accepted - acc0, issued - iss0);
        check_count("free_count", CNT_W'(NUM_ENTRIES), free_count);
        report_test("random mix");
    endtask

    initial begin
        drive_idle();
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        test_num    = 0;
        accepted    = 0;
        issued      = 0;
        last_acc    = 0;
        next_id     = '0;
        void'($urandom(51818));
        test_reset();
        test_dual();
        test_wakeup();
        test_fill();
        test_flush();
        test_random();
        $display("summary: %0d checks, %0d errors, %0d accepted, %0d issued",
                 checks, errors, accepted, issued);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
rs_types_pkg.sv
rs_uop_pkg.sv
rs_free_slot.sv
rs_entry_array.sv
rs_issue_select.sv
rs_dispatch_ctrl.sv
rs_top.sv
tb_clk_gen.sv
tb_rs.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then decide on the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_rs -f compile.f \
    && ./obj_dir/Vtb_rs > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Test completed successfully" sim.log && exit 0 || exit 1
